/* src/gauss_config.svh */
`ifndef GAUSS_CONFIG_SVH
`define GAUSS_CONFIG_SVH

// width of the systolic line, which is also the width of a column block
`define GAUSS_N 4

// number of matrix rows
`define GAUSS_L 12

// number of matrix columns, a multiple of GAUSS_N
`define GAUSS_K 16

`endif

/* src/gauss_pkg.sv */
package gauss_pkg;

`include "gauss_config.svh"

  typedef logic [`GAUSS_N-1:0] row_t;                              // row slice of one block
  typedef logic [$clog2(`GAUSS_L*`GAUSS_K/`GAUSS_N)-1:0] maddr_t; // matrix word address
  typedef logic [$clog2(`GAUSS_K/`GAUSS_N)-1:0] blk_t;            // column block index
  typedef logic [$clog2(`GAUSS_L+`GAUSS_N)-1:0] pos_t;            // stream position / op address

  // decision of one cell for one item
  typedef enum logic [1:0] {
    OP_PASS  = 2'd0,
    OP_ADD   = 2'd1,
    OP_STORE = 2'd2
  } op_t;

  typedef op_t [`GAUSS_N-1:0] op_vec_t; // slot j written by cell j

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_STREAM,  // issuing rows, then flush entries
    ST_DRAIN    // waiting for the line to empty
  } step_state_t;

endpackage

/* src/gauss_ram.sv */
`timescale 1ns/1ps

module gauss_ram #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 16
) (
  input  logic                     clk,
  input  logic                     wr_en,
  input  logic [$clog2(DEPTH)-1:0] wr_addr,
  input  logic [WIDTH-1:0]         wr_data,
  input  logic                     rd_en,
  input  logic [$clog2(DEPTH)-1:0] rd_addr,
  output logic [WIDTH-1:0]         rd_data
);

  logic [WIDTH-1:0] mem [DEPTH];

  // synchronous write
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // registered read, old data on a same-address collision
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

/* src/elim_cell.sv */
`timescale 1ns/1ps

module elim_cell import gauss_pkg::*; #(
  parameter int IDX = 0 // column handled by this cell
) (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    clear,
  input  logic    pivot_mode,
  input  logic    in_valid,
  input  row_t    in_row,
  input  logic    in_keep,
  input  logic    in_flush,
  input  op_vec_t in_ops,
  output logic    out_valid,
  output row_t    out_row,
  output logic    out_keep,
  output logic    out_flush,
  output op_vec_t out_ops,
  output logic    empty
);

  row_t    pivot;
  logic    occupied;
  logic    found;    // pivot seen since the last clear, survives the flush
  op_t     op;
  row_t    row_n;
  logic    keep_n;
  op_vec_t ops_n;

  always_comb begin
    op     = OP_PASS;
    row_n  = in_row;
    keep_n = in_keep;
    if (in_flush) begin
      // a flush item still free picks up this cell's pivot
      if (!in_keep) begin
        row_n  = occupied ? pivot : '0;
        keep_n = occupied;
      end
    end else begin
      if (pivot_mode) begin
        if (in_keep && in_row[IDX]) begin
          op = occupied ? OP_ADD : OP_STORE;
        end
      end else begin
        op = in_ops[IDX]; // replay
      end
      case (op)
        OP_ADD: row_n = in_row ^ pivot;
        OP_STORE: begin
          row_n  = '0;
          keep_n = 1'b0;
        end
        default: ;
      endcase
    end
    ops_n      = in_ops;
    ops_n[IDX] = op;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      occupied  <= 1'b0;
      found     <= 1'b0;
      out_valid <= 1'b0;
    end else if (clear) begin
      occupied  <= 1'b0;
      found     <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
      if (in_valid && in_flush && !in_keep) begin
        occupied <= 1'b0; // pivot handed over
      end
      if (in_valid && op == OP_STORE) begin
        occupied <= 1'b1;
        found    <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      out_row   <= row_n;
      out_keep  <= keep_n;
      out_flush <= in_flush;
      out_ops   <= ops_n;
    end
    if (in_valid && op == OP_STORE) begin
      pivot <= in_row;
    end
  end

  assign empty = !found;

endmodule

/* src/elim_line.sv */
`timescale 1ns/1ps

`include "gauss_config.svh"

module elim_line import gauss_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    clear,
  input  logic    pivot_mode,
  input  logic    in_valid,
  input  row_t    in_row,
  input  logic    in_keep,
  input  logic    in_flush,
  input  op_vec_t in_ops,
  output logic    out_valid,
  output row_t    out_row,
  output logic    out_keep,
  output op_vec_t out_ops,
  output logic    any_empty
);

  localparam int N = `GAUSS_N;

  // index j feeds cell j and index N is the line output
  logic [N:0]   valid_c;
  logic [N:0]   keep_c;
  logic [N:0]   flush_c;
  row_t         row_c [N+1];
  op_vec_t      ops_c [N+1];
  logic [N-1:0] empty_c;

  assign valid_c[0] = in_valid;
  assign row_c[0]   = in_row;
  assign keep_c[0]  = in_keep;
  assign flush_c[0] = in_flush;
  assign ops_c[0]   = in_ops;

  for (genvar j = 0; j < N; j++) begin : g_cell
    elim_cell #(.IDX(j)) u_cell (
      .clk       (clk),
      .rst_n     (rst_n),
      .clear     (clear),
      .pivot_mode(pivot_mode),
      .in_valid  (valid_c[j]),
      .in_row    (row_c[j]),
      .in_keep   (keep_c[j]),
      .in_flush  (flush_c[j]),
      .in_ops    (ops_c[j]),
      .out_valid (valid_c[j+1]),
      .out_row   (row_c[j+1]),
      .out_keep  (keep_c[j+1]),
      .out_flush (flush_c[j+1]),
      .out_ops   (ops_c[j+1]),
      .empty     (empty_c[j])
    );
  end

  assign out_valid = valid_c[N]; // data and flush items alike
  assign out_row   = row_c[N];
  assign out_keep  = keep_c[N];
  assign out_ops   = ops_c[N];
  assign any_empty = |empty_c; // some column without a pivot

endmodule

/* src/step_ctrl.sv */
`timescale 1ns/1ps

`include "gauss_config.svh"

module step_ctrl import gauss_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        start,
  input  logic        pivot_mode,
  input  blk_t        col_block,
  input  logic        wr_en,
  input  maddr_t      wr_addr,
  input  row_t        wr_data,
  input  logic        rd_en,
  input  maddr_t      rd_addr,
  input  logic        line_out_valid,
  input  row_t        line_out_row,
  input  logic        line_out_keep,
  input  op_vec_t     line_out_ops,
  input  logic        line_any_empty,
  output logic        m_wr_en,
  output maddr_t      m_wr_addr,
  output row_t        m_wr_data,
  output logic        m_rd_en,
  output maddr_t      m_rd_addr,
  output logic        o_wr_en,
  output pos_t        o_wr_addr,
  output op_vec_t     o_wr_data,
  output logic        o_rd_en,
  output pos_t        o_rd_addr,
  output logic        line_clear,
  output logic        line_mode,
  output logic        line_in_valid,
  output logic        line_in_keep,
  output logic        line_in_flush,
  output logic        busy,
  output logic        done,
  output logic        fail
);

  localparam pos_t LAST_ROW = pos_t'(`GAUSS_L - 1);
  localparam pos_t LAST_POS = pos_t'(`GAUSS_L + `GAUSS_N - 1);

  step_state_t state;
  logic        mode_q;
  maddr_t      base_q;   // col_block * L
  pos_t        rd_pos;   // next item to issue
  pos_t        out_pos;  // item now at the line output
  pos_t        kept;     // words written back so far
  logic        d_valid;
  logic        d_keep;
  logic        d_flush;
  logic        empty_q;  // any_empty once the data rows are through
  logic        idle;
  logic        issue_row;
  logic        wb_en;
  logic        last_out;

  assign idle      = (state == ST_IDLE);
  assign issue_row = (state == ST_STREAM) && (rd_pos <= LAST_ROW);
  assign wb_en     = !idle && line_out_valid && line_out_keep;
  assign last_out  = (state == ST_DRAIN) && line_out_valid && (out_pos == LAST_POS);

  // host owns the matrix port while idle
  assign m_rd_en   = idle ? rd_en : issue_row;
  assign m_rd_addr = idle ? rd_addr : base_q + maddr_t'(rd_pos);
  assign m_wr_en   = idle ? wr_en : wb_en;
  assign m_wr_addr = idle ? wr_addr : base_q + maddr_t'(kept); // compacted in place
  assign m_wr_data = idle ? wr_data : line_out_row;

  assign o_rd_en   = (state == ST_STREAM);
  assign o_rd_addr = rd_pos;
  assign o_wr_en   = mode_q && !idle && line_out_valid; // record only in pivot mode
  assign o_wr_addr = out_pos;
  assign o_wr_data = line_out_ops;

  assign line_clear    = start && idle;
  assign line_mode     = mode_q;
  assign line_in_valid = d_valid;
  assign line_in_keep  = d_keep;
  assign line_in_flush = d_flush;
  assign busy          = !idle;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= ST_IDLE;
      mode_q  <= 1'b0;
      base_q  <= '0;
      rd_pos  <= '0;
      out_pos <= '0;
      kept    <= '0;
      d_valid <= 1'b0;
      d_keep  <= 1'b0;
      d_flush <= 1'b0;
      empty_q <= 1'b0;
      done    <= 1'b0;
      fail    <= 1'b0;
    end else begin
      done <= 1'b0;
      // aligned with the registered memory read
      d_valid <= (state == ST_STREAM);
      d_keep  <= issue_row;
      d_flush <= (state == ST_STREAM) && !issue_row;
      case (state)
        ST_IDLE: begin
          if (start) begin
            state   <= ST_STREAM;
            mode_q  <= pivot_mode;
            base_q  <= maddr_t'(col_block * `GAUSS_L);
            rd_pos  <= '0;
            out_pos <= '0;
            kept    <= '0;
            fail    <= 1'b0;
          end
        end
        ST_STREAM: begin
          rd_pos <= rd_pos + 1'b1;
          if (rd_pos == LAST_POS) state <= ST_DRAIN;
        end
        ST_DRAIN: begin
          if (last_out) begin
            state <= ST_IDLE;
            done  <= 1'b1;
            fail  <= mode_q && empty_q; // rank below N
          end
        end
        default: state <= ST_IDLE;
      endcase
      if (!idle && line_out_valid) begin
        out_pos <= out_pos + 1'b1;
        if (out_pos == LAST_ROW) empty_q <= line_any_empty;
      end
      if (wb_en) kept <= kept + 1'b1;
    end
  end

endmodule

/* src/gauss_step.sv */
`timescale 1ns/1ps

`include "gauss_config.svh"

module gauss_step import gauss_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   start,
  input  logic   pivot_mode,
  input  blk_t   col_block,
  input  logic   wr_en,
  input  maddr_t wr_addr,
  input  row_t   wr_data,
  input  logic   rd_en,
  input  maddr_t rd_addr,
  output row_t   rd_data,
  output logic   busy,
  output logic   done,
  output logic   fail
);

  localparam int MAT_DEPTH = `GAUSS_L * `GAUSS_K / `GAUSS_N;
  localparam int OP_DEPTH  = `GAUSS_L + `GAUSS_N;

  logic    m_wr_en, m_rd_en;
  maddr_t  m_wr_addr, m_rd_addr;
  row_t    m_wr_data, m_rd_data;
  logic    o_wr_en, o_rd_en;
  pos_t    o_wr_addr, o_rd_addr;
  op_vec_t o_wr_data;
  logic [$bits(op_vec_t)-1:0] o_rd_data;
  op_vec_t line_in_ops, line_out_ops;
  logic    line_clear, line_mode, line_in_valid, line_in_keep, line_in_flush;
  logic    line_out_valid, line_out_keep, line_any_empty;
  row_t    line_out_row;

  assign rd_data     = m_rd_data;         // host read and line input share the port
  assign line_in_ops = op_vec_t'(o_rd_data);

  step_ctrl u_ctrl (
    .clk(clk), .rst_n(rst_n), .start(start), .pivot_mode(pivot_mode),
    .col_block(col_block), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
    .rd_en(rd_en), .rd_addr(rd_addr), .line_out_valid(line_out_valid),
    .line_out_row(line_out_row), .line_out_keep(line_out_keep),
    .line_out_ops(line_out_ops), .line_any_empty(line_any_empty),
    .m_wr_en(m_wr_en), .m_wr_addr(m_wr_addr), .m_wr_data(m_wr_data),
    .m_rd_en(m_rd_en), .m_rd_addr(m_rd_addr), .o_wr_en(o_wr_en),
    .o_wr_addr(o_wr_addr), .o_wr_data(o_wr_data), .o_rd_en(o_rd_en),
    .o_rd_addr(o_rd_addr), .line_clear(line_clear), .line_mode(line_mode),
    .line_in_valid(line_in_valid), .line_in_keep(line_in_keep),
    .line_in_flush(line_in_flush), .busy(busy), .done(done), .fail(fail)
  );

  gauss_ram #(.WIDTH(`GAUSS_N), .DEPTH(MAT_DEPTH)) u_matrix_ram (
    .clk(clk), .wr_en(m_wr_en), .wr_addr(m_wr_addr), .wr_data(m_wr_data),
    .rd_en(m_rd_en), .rd_addr(m_rd_addr), .rd_data(m_rd_data)
  );

  gauss_ram #(.WIDTH($bits(op_vec_t)), .DEPTH(OP_DEPTH)) u_op_ram (
    .clk(clk), .wr_en(o_wr_en), .wr_addr(o_wr_addr), .wr_data(o_wr_data),
    .rd_en(o_rd_en), .rd_addr(o_rd_addr), .rd_data(o_rd_data)
  );

  elim_line u_line (
    .clk(clk), .rst_n(rst_n), .clear(line_clear), .pivot_mode(line_mode),
    .in_valid(line_in_valid), .in_row(m_rd_data), .in_keep(line_in_keep),
    .in_flush(line_in_flush), .in_ops(line_in_ops), .out_valid(line_out_valid),
    .out_row(line_out_row), .out_keep(line_out_keep), .out_ops(line_out_ops),
    .any_empty(line_any_empty)
  );

endmodule

/* testbench/gauss_step_checker.sv */
`timescale 1ns/1ps

module gauss_step_checker (
  input logic clk,
  input logic rst_n,
  input logic start,
  input logic busy,
  input logic done,
  input logic fail,
  input logic m_wr_en,
  input logic line_out_valid,
  input logic line_out_keep
);

  int assert_errors = 0; // read by the testbench at the end

  done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
    else begin
      $error("done stayed high for more than one cycle");
      assert_errors++;
    end

  busy_fall: assert property (@(posedge clk) disable iff (!rst_n) $fell(busy) |-> done)
    else begin
      $error("busy fell without a done pulse");
      assert_errors++;
    end

  // fail only moves at an accepted start or with done
  fail_hold: assert property (@(posedge clk) disable iff (!rst_n)
    $changed(fail) |-> (($past(start) && !$past(busy)) || done))
    else begin
      $error("fail changed outside of start and done");
      assert_errors++;
    end

  // during a step only the line writes back
  no_host_write: assert property (@(posedge clk) disable iff (!rst_n)
    busy |-> (m_wr_en == (line_out_valid && line_out_keep)))
    else begin
      $error("matrix written by the host port while busy");
      assert_errors++;
    end

endmodule

/* testbench/tb_gauss_step.sv */
`timescale 1ns/1ps

`include "gauss_config.svh"

module tb_gauss_step import gauss_pkg::*; ();

  localparam int N         = `GAUSS_N;
  localparam int L         = `GAUSS_L;
  localparam int BLOCKS    = `GAUSS_K / `GAUSS_N;
  localparam int MAT_DEPTH = L * BLOCKS;
  localparam int LATENCY   = L + 2 * N + 2; // start cycle to done cycle
  localparam int TIMEOUT   = 200;

  logic   clk;
  logic   rst_n;
  logic   start;
  logic   pivot_mode;
  blk_t   col_block;
  logic   wr_en;
  maddr_t wr_addr;
  row_t   wr_data;
  logic   rd_en;
  maddr_t rd_addr;
  row_t   rd_data;
  logic   busy;
  logic   done;
  logic   fail;

  row_t        model_mem [MAT_DEPTH];
  op_t         model_ops [L+N][N]; // ops of the latest pivot step
  logic [31:0] seed;
  int          check_errors;
  int          timeout_errors;

  gauss_step i_gauss_step (
    .clk(clk), .rst_n(rst_n), .start(start), .pivot_mode(pivot_mode),
    .col_block(col_block), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
    .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data), .busy(busy),
    .done(done), .fail(fail)
  );

  bind step_ctrl gauss_step_checker u_checker (
    .clk(clk), .rst_n(rst_n), .start(start), .busy(busy), .done(done), .fail(fail),
    .m_wr_en(m_wr_en), .line_out_valid(line_out_valid), .line_out_keep(line_out_keep)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  function automatic logic [31:0] next_random();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    assert (got === exp) else begin
      $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
      check_errors++;
    end
  endtask

  task automatic host_write(input int addr, input row_t data);
    wr_en   = 1'b1;
    wr_addr = maddr_t'(addr);
    wr_data = data;
    @(negedge clk);
    wr_en = 1'b0;
    model_mem[addr] = data;
  endtask

  // random rows, optionally masked or seeded with unit rows
  task automatic fill_block(input int blk, input row_t mask, input bit identity);
    row_t data;
    for (int r = 0; r < L; r++) begin
      data = row_t'(next_random() >> 16) & mask;
      if (identity && r % (L / N) == 0 && r / (L / N) < N) data = row_t'(1 << (r / (L / N)));
      host_write(blk * L + r, data);
    end
  endtask

  task automatic verify_matrix();
    for (int a = 0; a < MAT_DEPTH; a++) begin
      rd_en   = 1'b1;
      rd_addr = maddr_t'(a);
      @(negedge clk); // data registered on the edge in between
      compare_value($sformatf("rd_data at 0x%0h", a), rd_data, model_mem[a]);
    end
    rd_en = 1'b0;
  endtask

  // runs every item through the cells one after the other
  task automatic model_step(input bit mode, input int blk, output bit fail_exp);
    row_t src [L];
    row_t piv [N];
    bit   occ [N];
    bit   found [N];
    row_t row;
    bit   keep;
    op_t  op;
    int   kept;
    for (int r = 0; r < L; r++) src[r] = model_mem[blk * L + r];
    for (int j = 0; j < N; j++) begin
      piv[j]   = '0;
      occ[j]   = 1'b0;
      found[j] = 1'b0;
    end
    kept = 0;
    for (int p = 0; p < L + N; p++) begin
      row  = (p < L) ? src[p] : '0;
      keep = (p < L);
      for (int j = 0; j < N; j++) begin
        op = OP_PASS;
        if (p >= L) begin
          if (!keep && occ[j]) begin // free flush entry picks up the pivot
            row    = piv[j];
            keep   = 1'b1;
            occ[j] = 1'b0;
          end
        end else if (mode) begin
          if (keep && row[j]) op = occ[j] ? OP_ADD : OP_STORE;
        end else begin
          op = model_ops[p][j]; // replay
        end
        if (op == OP_ADD) row = row ^ piv[j];
        if (op == OP_STORE) begin
          piv[j]   = row;
          occ[j]   = 1'b1;
          found[j] = 1'b1;
          row      = '0;
          keep     = 1'b0;
        end
        if (mode) model_ops[p][j] = op;
      end
      if (keep) begin
        model_mem[blk * L + kept] = row; // compacted in place
        kept++;
      end
    end
    fail_exp = 1'b0;
    for (int j = 0; j < N; j++) if (mode && !found[j]) fail_exp = 1'b1;
  endtask

  task automatic check_op_memory();
    logic [2*N-1:0] exp_word;
    for (int p = 0; p < L + N; p++) begin
      exp_word = '0;
      for (int j = 0; j < N; j++) exp_word[2*j +: 2] = model_ops[p][j];
      compare_value($sformatf("op word at 0x%0h", p), i_gauss_step.u_op_ram.mem[p], exp_word);
    end
  endtask

  task automatic run_step(input bit mode, input int blk, input bit disturb);
    bit          fail_exp;
    int          cycles;
    int          dones;
    logic [31:0] rnd;
    model_step(mode, blk, fail_exp);
    start      = 1'b1;
    pivot_mode = mode;
    col_block  = blk_t'(blk);
    cycles     = 0;
    dones      = 0;
    while (dones == 0 && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
      if (done) dones++;
      if (cycles == 1) compare_value("busy", busy, 1);
      if (disturb && busy) begin // restart and host writes, all to be ignored
        rnd        = next_random();
        start      = 1'b1;
        pivot_mode = rnd[0];
        col_block  = blk_t'(rnd >> 8);
        wr_en      = 1'b1;
        wr_addr    = maddr_t'((rnd >> 16) % MAT_DEPTH);
        wr_data    = row_t'(rnd >> 24);
      end else begin
        start = 1'b0;
        wr_en = 1'b0;
      end
    end
    start = 1'b0;
    wr_en = 1'b0;
    if (dones == 0) begin
      $display("timeout while waiting for done on block %0d", blk);
      timeout_errors++;
    end else begin
      compare_value("done latency", cycles, LATENCY);
      compare_value("fail", fail, fail_exp);
      compare_value("busy", busy, 0);
    end
    if (disturb) begin
      for (int c = 0; c < LATENCY + 8; c++) begin
        @(negedge clk);
        if (done) dones++;
      end
      compare_value("done count", dones, 1);
    end
    pivot_mode = 1'b0;
  endtask

  initial begin
    int blk;
    int other;
    seed           = 32'h37a1;
    check_errors   = 0;
    timeout_errors = 0;
    rst_n      = 1'b0;
    start      = 1'b0;
    pivot_mode = 1'b0;
    col_block  = '0;
    wr_en      = 1'b0;
    wr_addr    = '0;
    wr_data    = '0;
    rd_en      = 1'b0;
    rd_addr    = '0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    compare_value("done", done, 0);
    compare_value("fail", fail, 0);
    compare_value("busy", busy, 0);

    // host port round trip over the whole matrix
    for (int a = 0; a < MAT_DEPTH; a++) host_write(a, row_t'(next_random() >> 16));
    verify_matrix();

    // pivot steps, each followed by a replay on another block
    for (int i = 0; i < 24; i++) begin
      blk = (next_random() >> 16) % BLOCKS;
      fill_block(blk, (i % 4 == 1) ? row_t'((1 << (N - 1)) - 1) : '1, i % 3 == 0);
      run_step(1'b1, blk, 1'b0);
      check_op_memory();
      verify_matrix();
      other = (blk + 1 + (next_random() >> 16) % (BLOCKS - 1)) % BLOCKS;
      fill_block(other, '1, 1'b0);
      run_step(1'b0, other, 1'b0);
      verify_matrix();
    end

    fill_block(blk, '0, 1'b0); // all-zero block
    run_step(1'b1, blk, 1'b0);
    compare_value("fail", fail, 1);
    verify_matrix();

    fill_block(blk, '1, 1'b1);
    run_step(1'b1, blk, 1'b1);
    verify_matrix();
    run_step(1'b0, other, 1'b1);
    verify_matrix();

    $display("error counts: %0d check, %0d timeout, %0d assertion", check_errors,
             timeout_errors, i_gauss_step.u_ctrl.u_checker.assert_errors);
    if (check_errors + timeout_errors + i_gauss_step.u_ctrl.u_checker.assert_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* project.f */
+incdir+src
src/gauss_pkg.sv
src/gauss_ram.sv
src/elim_cell.sv
src/elim_line.sv
src/step_ctrl.sv
src/gauss_step.sv
testbench/gauss_step_checker.sv
testbench/tb_gauss_step.sv

/* Bender.yml */
package:
  name: gauss_step

sources:
  - include_dirs:
      - src
    files:
      - src/gauss_pkg.sv
      - src/gauss_ram.sv
      - src/elim_cell.sv
      - src/elim_line.sv
      - src/step_ctrl.sv
      - src/gauss_step.sv
  - target: test
    include_dirs:
      - src
    files:
      - testbench/gauss_step_checker.sv
      - testbench/tb_gauss_step.sv
